// ==== dv/uncache_axi_stim.txt ====
# name op addr size wdata wstrb expected, all numbers hex except size (0 byte, 1 half, 2 word)
# op I inst read, R data read, W data write, P inst and data read (wdata column = inst address)
inst_0 I 00000100 2 00000000 0 A5A50100
inst_1 I 00001ff8 2 00000000 0 A5A51FF8
inst_hi I 7ffe0010 2 00000000 0 DA5B0010
rd_byte R 00000203 0 00000000 0 A5A50200
rd_half R 00000206 1 00000000 0 A5A50204
rd_word R 00003000 2 00000000 0 A5A53000
rd_hi_word R 8000fffc 2 00000000 0 25A5FFFC
wr_lo_half W 00000400 1 0000beef 3 00000000
rd_after_lo R 00000400 2 00000000 0 A5A5BEEF
wr_byte2 W 00000502 0 00770000 4 00000000
rd_after_b2 R 00000500 2 00000000 0 A5770500
wr_word W 00000600 2 12345678 f 00000000
rd_after_word R 00000600 2 00000000 0 12345678
inst_after_wr I 00000600 2 00000000 0 12345678
wr_mixed W 00000700 2 11223344 9 00000000
rd_after_mixed R 00000700 1 00000000 0 11A50744
pair_0 P 00000800 2 00000900 0 A5A50800
pair_1 P 00000a04 0 00000b00 0 A5A50A04

// ==== uncache_axi.f ====
+incdir+logic
logic/axi_pkg.sv
logic/cpu_bus_pkg.sv
logic/inst_uncache.sv
logic/data_uncache.sv
logic/axi_read_arbiter.sv
logic/uncache_axi_top.sv
dv/axi_slave_model.sv
dv/uncache_axi_tb.sv

// ==== Bender.yml ====
package:
  name: uncache_axi

export_include_dirs:
  - logic

sources:
  - logic/axi_pkg.sv
  - logic/cpu_bus_pkg.sv
  - logic/inst_uncache.sv
  - logic/data_uncache.sv
  - logic/axi_read_arbiter.sv
  - logic/uncache_axi_top.sv
  - target: simulation
    files:
      - dv/axi_slave_model.sv
      - dv/uncache_axi_tb.sv

// ==== dv/uncache_axi_tb.sv ====
`include "axi_bridge_defines.svh"

module uncache_axi_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import axi_pkg::*;
    import cpu_bus_pkg::*;

    logic      aclk;
    logic      rst_n;
    logic      inst_req;
    addr_t     inst_addr;
    logic      inst_addr_ok;
    logic      inst_data_ok;
    word_t     inst_rdata;
    logic      data_req;
    logic      data_wr;
    acc_size_t data_size;
    addr_t     data_addr;
    word_t     data_wdata;
    strb_t     data_wstrb;
    word_t     data_rdata;
    logic      data_addr_ok;
    logic      data_data_ok;
    axi_id_t   arid;
    addr_t     araddr;
    axi_size_t arsize;
    logic      arvalid;
    logic      arready;
    axi_id_t   rid;
    word_t     rdata;
    logic      rlast;
    logic      rvalid;
    logic      rready;
    addr_t     awaddr;
    axi_size_t awsize;
    logic      awvalid;
    logic      awready;
    word_t     wdata;
    strb_t     wstrb;
    logic      wvalid;
    logic      wready;
    logic      bvalid;
    logic      bready;

    // One entry per stim line
    string                 test_names[$];
    logic [7:0]            test_ops[$];
    logic [`AXI_ADDR_W-1:0] test_addrs[$];
    logic [1:0]            test_sizes[$];
    logic [`AXI_DATA_W-1:0] test_wdatas[$];
    logic [`AXI_STRB_W-1:0] test_strbs[$];
    logic [`AXI_DATA_W-1:0] test_exps[$];

    // Handshakes seen during the current test
    addr_t     ar_addr_seen[$];
    axi_id_t   ar_id_seen[$];
    axi_size_t ar_size_seen[$];
    addr_t     aw_addr_seen[$];
    axi_size_t aw_size_seen[$];
    strb_t     w_strb_seen[$];

    string cur_name = "startup";
    int    test_errs = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    cycle_limit = 0;
    int    cycle_count = 0;
    logic  ar_pend = 1'b0;
    logic  aw_pend = 1'b0;
    logic  w_pend = 1'b0;
    addr_t ar_hold;
    addr_t aw_hold;
    word_t w_hold;

    uncache_axi_top u_uncache_axi_top (.*);

    axi_slave_model u_axi_slave_model (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic check(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    // Memory contents before any write
    function automatic word_t preload_word(input addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A50000;
    endfunction

    task automatic load_stim(output int ok);
        int          fd;
        int          n;
        int          sz;
        string       line;
        string       nm;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] st;
        logic [31:0] ex;
        ok = 0;
        fd = $fopen("dv/uncache_axi_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %c %h %d %h %h %h", nm, op, a, sz, wd, st, ex);
                    if (n == 7) begin
                        test_names.push_back(nm);
                        test_ops.push_back(op);
                        test_addrs.push_back(a);
                        test_sizes.push_back(sz[1:0]);
                        test_wdatas.push_back(wd);
                        test_strbs.push_back(st[3:0]);
                        test_exps.push_back(ex);
                    end
                end
            end
            $fclose(fd);
            ok = (test_names.size() > 0);
            cycle_limit = test_names.size() * 40 + 100;
        end
    endtask

    task automatic start_test(input string name);
        cur_name = name;
        test_errs = 0;
        ar_addr_seen.delete();
        ar_id_seen.delete();
        ar_size_seen.delete();
        aw_addr_seen.delete();
        aw_size_seen.delete();
        w_strb_seen.delete();
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS %s", cur_name);
        end else begin
            fail_count++;
            $display("FAIL %s", cur_name);
        end
    endtask

    task automatic run_inst(input addr_t addr, output word_t result);
        inst_req  = 1'b1;
        inst_addr = addr;
        @(posedge aclk);
        while (!inst_addr_ok) @(posedge aclk);
        #1;
        inst_req = 1'b0;
        @(posedge aclk);
        while (!inst_data_ok) @(posedge aclk);
        result = inst_rdata;
    endtask

    task automatic run_data(input int i, output word_t result);
        data_req   = 1'b1;
        data_wr    = (test_ops[i] == "W");
        data_size  = acc_size_t'(test_sizes[i]);
        data_addr  = test_addrs[i];
        data_wdata = test_wdatas[i];
        data_wstrb = test_strbs[i];
        @(posedge aclk);
        while (!data_addr_ok) @(posedge aclk);
        #1;
        data_req = 1'b0;
        @(posedge aclk);
        while (!data_data_ok) @(posedge aclk);
        result = data_rdata;
    endtask

    task automatic check_reset_idle();
        start_test("reset_idle");
        repeat (3) begin
            @(posedge aclk);
            check({cur_name, " control outputs"}, 0,
                  {arvalid, awvalid, wvalid, rready, bready,
                   inst_addr_ok, inst_data_ok, data_addr_ok, data_data_ok});
        end
        finish_test();
    endtask

    task automatic run_test(input int i);
        word_t got_i;
        word_t got_d;
        start_test(test_names[i]);
        @(posedge aclk);
        #1;
        case (test_ops[i])
            "I": begin
                run_inst(test_addrs[i], got_i);
                check({cur_name, " rdata"}, test_exps[i], got_i);
                check({cur_name, " ar count"}, 1, ar_addr_seen.size());
                check({cur_name, " araddr"}, test_addrs[i], ar_addr_seen[0]);
                check({cur_name, " arid"}, ID_INST, ar_id_seen[0]);
            end
            "R": begin
                run_data(i, got_d);
                check({cur_name, " rdata"}, test_exps[i], got_d);
                check({cur_name, " ar count"}, 1, ar_addr_seen.size());
                check({cur_name, " araddr"}, test_addrs[i], ar_addr_seen[0]);
                check({cur_name, " arsize"}, test_sizes[i], ar_size_seen[0]);
                check({cur_name, " arid"}, ID_DATA, ar_id_seen[0]);
            end
            "W": begin
                run_data(i, got_d);
                check({cur_name, " aw count"}, 1, aw_addr_seen.size());
                check({cur_name, " awaddr"}, test_addrs[i], aw_addr_seen[0]);
                check({cur_name, " awsize"}, test_sizes[i], aw_size_seen[0]);
                check({cur_name, " wstrb"}, test_strbs[i], w_strb_seen[0]);
            end
            "P": begin
                // Instruction address rides in the wdata column
                fork
                    run_inst(test_wdatas[i], got_i);
                    run_data(i, got_d);
                join
                check({cur_name, " ar count"}, 2, ar_addr_seen.size());
                check({cur_name, " first araddr"}, test_addrs[i], ar_addr_seen[0]);
                check({cur_name, " data rdata"}, test_exps[i], got_d);
                check({cur_name, " inst rdata"}, preload_word(test_wdatas[i]), got_i);
            end
            default: begin
                $display("Test %s has an unknown operation code", cur_name);
                test_errs++;
            end
        endcase
        finish_test();
    endtask

    // Handshake capture and hold checks while a valid waits for ready
    always @(posedge aclk) begin
        if (rst_n) begin
            if (arvalid && arready) begin
                ar_addr_seen.push_back(araddr);
                ar_id_seen.push_back(arid);
                ar_size_seen.push_back(arsize);
            end
            if (awvalid && awready) begin
                aw_addr_seen.push_back(awaddr);
                aw_size_seen.push_back(awsize);
            end
            if (wvalid && wready) w_strb_seen.push_back(wstrb);
            if (ar_pend) begin
                check({cur_name, " arvalid hold"}, 1, arvalid);
                check({cur_name, " araddr hold"}, ar_hold, araddr);
            end
            if (aw_pend) begin
                check({cur_name, " awvalid hold"}, 1, awvalid);
                check({cur_name, " awaddr hold"}, aw_hold, awaddr);
            end
            if (w_pend) begin
                check({cur_name, " wvalid hold"}, 1, wvalid);
                check({cur_name, " wdata hold"}, w_hold, wdata);
            end
            ar_pend = arvalid && !arready;
            aw_pend = awvalid && !awready;
            w_pend  = wvalid && !wready;
            ar_hold = araddr;
            aw_hold = awaddr;
            w_hold  = wdata;
        end
    end

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int ok;
        rst_n      = 1'b0;
        inst_req   = 1'b0;
        inst_addr  = '0;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = SIZE_WORD;
        data_addr  = '0;
        data_wdata = '0;
        data_wstrb = '0;
        load_stim(ok);
        repeat (4) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        if (!ok) begin
            $display("Could not read any test from dv/uncache_axi_stim.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            check_reset_idle();
            for (int i = 0; i < test_names.size(); i++) begin
                run_test(i);
            end
            $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// ==== dv/axi_slave_model.sv ====
`include "axi_bridge_defines.svh"

module axi_slave_model (
    input  logic               aclk,
    input  logic               rst_n,
    input  axi_pkg::axi_id_t   arid,
    input  cpu_bus_pkg::addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::axi_id_t   rid,
    output cpu_bus_pkg::word_t rdata,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  cpu_bus_pkg::addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  cpu_bus_pkg::word_t wdata,
    input  cpu_bus_pkg::strb_t wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready
);
    timeunit 1ns;
    timeprecision 100ps;

    import axi_pkg::*;
    import cpu_bus_pkg::*;

    // Only written words are stored and the rest follow the preload rule
    word_t       mem [addr_t];
    logic [31:0] lcg_state = 32'hf07e8c63;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Wait of 0 to 3 cycles before a ready
    task automatic ready_delay();
        int d;
        lcg_state = lcg_next(lcg_state);
        d = lcg_state[31:30];
        repeat (d) @(posedge aclk);
    endtask

    function automatic word_t read_word(input addr_t addr);
        addr_t wa;
        wa = {addr[31:2], 2'b00};
        if (mem.exists(wa)) return mem[wa];
        return wa ^ 32'hA5A50000;
    endfunction

    // One read beat per request
    initial begin
        axi_id_t id_q;
        addr_t   addr_q;
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        rlast   = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge aclk);
            if (arvalid) begin
                ready_delay();
                #1;
                arready = 1'b1;
                @(posedge aclk);
                id_q   = arid;
                addr_q = araddr;
                #1;
                arready = 1'b0;
                rvalid  = 1'b1;
                rid     = id_q;
                rdata   = read_word(addr_q);
                rlast   = 1'b1;
                @(posedge aclk);
                while (!rready) @(posedge aclk);
                #1;
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

    // AW and W accepted on their own delays
    initial begin
        addr_t aw_q;
        word_t w_q;
        strb_t s_q;
        word_t merged;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge aclk);
            if (awvalid && wvalid) begin
                fork
                    begin
                        ready_delay();
                        #1;
                        awready = 1'b1;
                        @(posedge aclk);
                        aw_q = awaddr;
                        #1;
                        awready = 1'b0;
                    end
                    begin
                        ready_delay();
                        #1;
                        wready = 1'b1;
                        @(posedge aclk);
                        w_q = wdata;
                        s_q = wstrb;
                        #1;
                        wready = 1'b0;
                    end
                join
                merged = read_word(aw_q);
                for (int b = 0; b < `AXI_STRB_W; b++) begin
                    if (s_q[b]) begin
                        merged[8*b +: 8] = w_q[8*b +: 8];
                    end
                end
                mem[{aw_q[31:2], 2'b00}] = merged;
                bvalid = 1'b1;
                @(posedge aclk);
                while (!bready) @(posedge aclk);
                #1;
                bvalid = 1'b0;
            end
        end
    end

endmodule

// ==== logic/uncache_axi_top.sv ====
module uncache_axi_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   inst_req,
    input  cpu_bus_pkg::addr_t     inst_addr,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,
    output cpu_bus_pkg::word_t     inst_rdata,
    input  logic                   data_req,
    input  logic                   data_wr,
    input  cpu_bus_pkg::acc_size_t data_size,
    input  cpu_bus_pkg::addr_t     data_addr,
    input  cpu_bus_pkg::word_t     data_wdata,
    input  cpu_bus_pkg::strb_t     data_wstrb,
    output cpu_bus_pkg::word_t     data_rdata,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output axi_pkg::axi_id_t       arid,
    output cpu_bus_pkg::addr_t     araddr,
    output axi_pkg::axi_size_t     arsize,
    output logic                   arvalid,
    input  logic                   arready,
    input  axi_pkg::axi_id_t       rid,
    input  cpu_bus_pkg::word_t     rdata,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    output cpu_bus_pkg::addr_t     awaddr,
    output axi_pkg::axi_size_t     awsize,
    output logic                   awvalid,
    input  logic                   awready,
    output cpu_bus_pkg::word_t     wdata,
    output cpu_bus_pkg::strb_t     wstrb,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);
    import cpu_bus_pkg::*;
    import axi_pkg::*;

    logic      inst_ar_valid;
    addr_t     inst_ar_addr;
    logic      inst_ar_ready;
    logic      inst_r_valid;
    logic      inst_r_ready;
    logic      data_ar_valid;
    addr_t     data_ar_addr;
    axi_size_t data_ar_size;
    logic      data_ar_ready;
    logic      data_r_valid;
    logic      data_r_ready;
    word_t     r_data;

    inst_uncache u_inst_uncache (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .ar_ready     (inst_ar_ready),
        .r_valid      (inst_r_valid),
        .r_data       (r_data),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .ar_valid     (inst_ar_valid),
        .ar_addr      (inst_ar_addr),
        .r_ready      (inst_r_ready)
    );

    // Write channel goes straight to the external ports
    data_uncache u_data_uncache (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_wstrb   (data_wstrb),
        .ar_ready     (data_ar_ready),
        .r_valid      (data_r_valid),
        .r_data       (r_data),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .ar_valid     (data_ar_valid),
        .ar_addr      (data_ar_addr),
        .ar_size      (data_ar_size),
        .r_ready      (data_r_ready),
        .awaddr       (awaddr),
        .awsize       (awsize),
        .awvalid      (awvalid),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .bready       (bready)
    );

    axi_read_arbiter u_axi_read_arbiter (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .inst_ar_valid (inst_ar_valid),
        .inst_ar_addr  (inst_ar_addr),
        .inst_r_ready  (inst_r_ready),
        .data_ar_valid (data_ar_valid),
        .data_ar_addr  (data_ar_addr),
        .data_ar_size  (data_ar_size),
        .data_r_ready  (data_r_ready),
        .arready       (arready),
        .rid           (rid),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .inst_ar_ready (inst_ar_ready),
        .inst_r_valid  (inst_r_valid),
        .data_ar_ready (data_ar_ready),
        .data_r_valid  (data_r_valid),
        .r_data        (r_data),
        .arid          (arid),
        .araddr        (araddr),
        .arsize        (arsize),
        .arvalid       (arvalid),
        .rready        (rready)
    );

endmodule

// ==== logic/axi_read_arbiter.sv ====
module axi_read_arbiter (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               inst_ar_valid,
    input  cpu_bus_pkg::addr_t inst_ar_addr,
    input  logic               inst_r_ready,
    input  logic               data_ar_valid,
    input  cpu_bus_pkg::addr_t data_ar_addr,
    input  axi_pkg::axi_size_t data_ar_size,
    input  logic               data_r_ready,
    input  logic               arready,
    input  axi_pkg::axi_id_t   rid,
    input  cpu_bus_pkg::word_t rdata,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               inst_ar_ready,
    output logic               inst_r_valid,
    output logic               data_ar_ready,
    output logic               data_r_valid,
    output cpu_bus_pkg::word_t r_data,
    output axi_pkg::axi_id_t   arid,
    output cpu_bus_pkg::addr_t araddr,
    output axi_pkg::axi_size_t arsize,
    output logic               arvalid,
    output logic               rready
);
    import cpu_bus_pkg::*;
    import axi_pkg::*;

    logic busy;
    logic owner_data;
    logic ar_sent;

    // Owner holds its valid until ready, so the grant alone drives arvalid
    assign arvalid = busy && !ar_sent;
    assign araddr  = owner_data ? data_ar_addr : inst_ar_addr;
    assign arsize  = owner_data ? data_ar_size : axi_size_t'({1'b0, SIZE_WORD});
    assign arid    = owner_data ? ID_DATA : ID_INST;

    assign inst_ar_ready = arvalid && !owner_data && arready;
    assign data_ar_ready = arvalid && owner_data && arready;

    // Return path steered by rid
    assign inst_r_valid = rvalid && (rid == ID_INST);
    assign data_r_valid = rvalid && (rid == ID_DATA);
    assign rready       = (rid == ID_DATA) ? data_r_ready : inst_r_ready;
    assign r_data       = rdata;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
            ar_sent    <= 1'b0;
        end else if (!busy) begin
            if (data_ar_valid || inst_ar_valid) begin
                busy       <= 1'b1;
                owner_data <= data_ar_valid;
                ar_sent    <= 1'b0;
            end
        end else begin
            if (arvalid && arready) ar_sent <= 1'b1;
            // Free the channel on the last beat
            if (rvalid && rready && rlast) busy <= 1'b0;
        end
    end

endmodule

// ==== logic/data_uncache.sv ====
module data_uncache (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  data_req,
    input  logic                  data_wr,
    input  cpu_bus_pkg::acc_size_t data_size,
    input  cpu_bus_pkg::addr_t    data_addr,
    input  cpu_bus_pkg::word_t    data_wdata,
    input  cpu_bus_pkg::strb_t    data_wstrb,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  cpu_bus_pkg::word_t    r_data,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output cpu_bus_pkg::word_t    data_rdata,
    output logic                  ar_valid,
    output cpu_bus_pkg::addr_t    ar_addr,
    output axi_pkg::axi_size_t    ar_size,
    output logic                  r_ready,
    output cpu_bus_pkg::addr_t    awaddr,
    output axi_pkg::axi_size_t    awsize,
    output logic                  awvalid,
    output cpu_bus_pkg::word_t    wdata,
    output cpu_bus_pkg::strb_t    wstrb,
    output logic                  wvalid,
    output logic                  bready
);
    import cpu_bus_pkg::*;
    import axi_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_ADDR,
        ST_RD_WAIT,
        ST_WR_REQ,
        ST_WR_RESP
    } state_t;

    state_t    state;
    logic      aw_done;
    logic      w_done;
    logic      aw_fin;
    logic      w_fin;
    acc_size_t size_q;
    addr_t     addr_q;
    word_t     wdata_q;
    strb_t     wstrb_q;

    assign data_addr_ok = (state == ST_IDLE) && data_req;

    assign ar_valid = (state == ST_RD_ADDR);
    assign ar_addr  = addr_q;
    assign ar_size  = axi_size_t'({1'b0, size_q});
    assign r_ready  = (state == ST_RD_WAIT);

    // AW and W complete independently of each other
    assign awvalid = (state == ST_WR_REQ) && !aw_done;
    assign wvalid  = (state == ST_WR_REQ) && !w_done;
    assign aw_fin  = aw_done || (awvalid && awready);
    assign w_fin   = w_done || (wvalid && wready);
    assign awaddr  = addr_q;
    assign awsize  = axi_size_t'({1'b0, size_q});
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;
    assign bready  = (state == ST_WR_RESP);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            data_data_ok <= 1'b0;
        end else begin
            data_data_ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (data_addr_ok) state <= data_wr ? ST_WR_REQ : ST_RD_ADDR;
                end
                ST_RD_ADDR: if (ar_ready) state <= ST_RD_WAIT;
                ST_RD_WAIT: begin
                    if (r_valid) begin
                        state        <= ST_IDLE;
                        data_data_ok <= 1'b1;
                    end
                end
                ST_WR_REQ: begin
                    aw_done <= aw_fin;
                    w_done  <= w_fin;
                    if (aw_fin && w_fin) state <= ST_WR_RESP;
                end
                ST_WR_RESP: begin
                    if (bvalid) begin
                        state        <= ST_IDLE;
                        data_data_ok <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Whole request captured at acceptance
    always_ff @(posedge aclk) begin
        if (data_addr_ok) begin
            size_q  <= data_size;
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
            wstrb_q <= data_wstrb;
        end
        if (r_ready && r_valid) data_rdata <= r_data;
    end

endmodule

// ==== logic/inst_uncache.sv ====
module inst_uncache (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               inst_req,
    input  cpu_bus_pkg::addr_t inst_addr,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  cpu_bus_pkg::word_t r_data,
    output logic               inst_addr_ok,
    output logic               inst_data_ok,
    output cpu_bus_pkg::word_t inst_rdata,
    output logic               ar_valid,
    output cpu_bus_pkg::addr_t ar_addr,
    output logic               r_ready
);
    import cpu_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT
    } state_t;

    state_t state;
    addr_t  addr_q;

    // Acceptance only while nothing is in flight
    assign inst_addr_ok = (state == ST_IDLE) && inst_req;
    assign ar_valid     = (state == ST_ADDR);
    assign ar_addr      = addr_q;
    assign r_ready      = (state == ST_WAIT);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            inst_data_ok <= 1'b0;
        end else begin
            inst_data_ok <= 1'b0;
            case (state)
                ST_IDLE: if (inst_addr_ok) state <= ST_ADDR;
                ST_ADDR: if (ar_ready) state <= ST_WAIT;
                ST_WAIT: begin
                    if (r_valid) begin
                        state        <= ST_IDLE;
                        inst_data_ok <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_addr_ok) addr_q <= inst_addr;
        if (r_ready && r_valid) inst_rdata <= r_data;
    end

endmodule

// ==== logic/cpu_bus_pkg.sv ====
`include "axi_bridge_defines.svh"

package cpu_bus_pkg;

    // Encoded as the low bits of the AXI size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_t;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] word_t;
    typedef logic [`AXI_STRB_W-1:0] strb_t;

endpackage

// ==== logic/axi_pkg.sv ====
`include "axi_bridge_defines.svh"

package axi_pkg;

    // Read transaction ID
    typedef logic [`AXI_ID_W-1:0] axi_id_t;

    // Beat size code, bytes = 2**size
    typedef logic [2:0] axi_size_t;

    // Fixed IDs that tell the two read requesters apart
    localparam axi_id_t ID_INST = axi_id_t'(0);
    localparam axi_id_t ID_DATA = axi_id_t'(1);

endpackage

// ==== logic/axi_bridge_defines.svh ====
`ifndef AXI_BRIDGE_DEFINES_SVH
`define AXI_BRIDGE_DEFINES_SVH

// Byte address on both the CPU and the AXI side
`define AXI_ADDR_W 32

// One bus word
`define AXI_DATA_W 32

// Read ID width
// Only two ID values are in use
`define AXI_ID_W 4

// One strobe bit per data byte
`define AXI_STRB_W 4

`endif
